// File: vlog.f
verilog/bus_pkg.sv
verilog/host_arbiter.sv
verilog/reg_bus_mux.sv
verilog/board_regs.sv
verilog/hub_mem.sv
verilog/fpga_reg_top.sv
+incdir+tests
tests/tb_fpga_reg.sv

// File: Makefile
# Verilator build and run of the shared register bus testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fpga_reg
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED
SOURCES   := $(wildcard verilog/*.sv tests/*.sv tests/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_tasks.svh
/*
 * Host-side APB driver tasks, the random data generator and the error
 * counters of the register bus testbench. Included inside tb_fpga_reg,
 * after its signal declarations.
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int          mismatch_cnt  = 0;                     // wrong read values
int          other_err_cnt = 0;                     // protocol, watchdog, timeout
int          xfer_cnt      = 0;                     // completed transfers, all hosts
logic [31:0] lcg_state     = LCG_SEED;

// ------------------------------
// data and addresses
// ------------------------------
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;        // full-period 32-bit LCG
endfunction

task automatic next_word(output logic [31:0] w);
    lcg_state = lcg_step(lcg_state);
    w = lcg_state;
endtask

function automatic logic [15:0] hub_addr(input int off);
    return {4'h1, off[11:0]};                       // hub space nibble
endfunction

// ------------------------------
// checks
// ------------------------------
task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        $display("Mismatch %s: expected %h, actual %h at %0t", test, exp, act, $time);
        mismatch_cnt++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
        $display("Error: %s at %0t", what, $time);
        other_err_cnt++;
    end
endtask

task automatic report_counts();
    $display("%0d transfers, %0d mismatches, %0d other errors",
             xfer_cnt, mismatch_cnt, other_err_cnt);
endtask

// ------------------------------
// APB host driver
// ------------------------------
// one transfer from host h, returns one cycle after pready
task automatic apb_xfer(input int h, input logic write, input logic [15:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic err);
    logic done;
    done = 1'b0;
    @(posedge sysclk);
    #5;
    host_req[h] = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge sysclk);
    #5;
    host_req[h].penable = 1'b1;                     // hold everything until pready
    while (!done) begin
        @(negedge sysclk);
        if (host_rsp[h].pready) begin
            rdata = host_rsp[h].prdata;
            err   = host_rsp[h].pslverr;
            done  = 1'b1;
        end
    end
    @(posedge sysclk);
    #5;
    host_req[h] = '0;
    xfer_cnt++;
endtask

task automatic bus_write(input string test, input int h, input logic [15:0] addr,
                         input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(h, 1'b1, addr, data, rd, err);
    check_value({test, " write pslverr"}, 32'd0, {31'd0, err});
endtask

task automatic read_check(input string test, input int h, input logic [15:0] addr,
                          input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(h, 1'b0, addr, 32'd0, rd, err);
    check_value(test, exp_data, rd);
    check_value({test, " pslverr"}, {31'd0, exp_err}, {31'd0, err});
endtask

`endif

// File: tests/tb_fpga_reg.sv
/*
 * Testbench for the shared register bus. Three host APB ports are driven
 * through hub round trips, contention, the main-space registers, error
 * responses and the watchdog. Compiled from vlog.f, top tb_fpga_reg.
 */

`timescale 1ns/1ps

module tb_fpga_reg;

    import bus_pkg::*;

    localparam int          WDOG_TICK_TB   = 4;
    localparam int          HUB_DEPTH_TB   = 64;
    localparam int          WDOG_PERIOD_TB = 3;
    localparam int          TIMEOUT_CYCLES = 4000;  // all tests need well under 1000
    localparam logic [31:0] LCG_SEED       = 32'h9197_a1c6;

    logic       sysclk;
    logic       rst_n;
    logic [3:0] board_id;
    logic       wdog_clear;
    logic       wdog_timeout;
    logic       wdog_busy;                          // writes keep coming, flag stays low
    apb_req_t   host_req [3];                       // rt, eth, fw
    apb_rsp_t   host_rsp [3];
    int         pready_seen [3];                    // pready cycles per host
    int         cycle_cnt;

    `include "tb_tasks.svh"

    fpga_reg_top #(.WDOG_TICK(WDOG_TICK_TB), .HUB_DEPTH(HUB_DEPTH_TB)) dut_i (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .rt_req(host_req[0]), .eth_req(host_req[1]), .fw_req(host_req[2]),
        .rt_rsp(host_rsp[0]), .eth_rsp(host_rsp[1]), .fw_rsp(host_rsp[2]),
        .wdog_clear(wdog_clear), .wdog_timeout(wdog_timeout)
    );

    always #50 sysclk = ~sysclk;                    // 100 ns period

    always @(negedge sysclk) begin
        for (int h = 0; h < 3; h++)
            if (host_rsp[h].pready)
                pready_seen[h]++;
    end

    // ------------------------------
    // assertions
    // ------------------------------
    a_reset_quiet: assert property (@(posedge sysclk) !rst_n |->
        !(host_rsp[0].pready || host_rsp[1].pready || host_rsp[2].pready || wdog_timeout))
        else begin
            $display("Error: pready or wdog_timeout high during reset at %0t", $time);
            other_err_cnt++;
        end
    a_one_ready: assert property (@(posedge sysclk) disable iff (!rst_n)
        $onehot0({host_rsp[0].pready, host_rsp[1].pready, host_rsp[2].pready}))
        else begin
            $display("Error: more than one host sees pready at %0t", $time);
            other_err_cnt++;
        end
    a_wdog_quiet: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_busy |-> !wdog_timeout)
        else begin
            $display("Error: wdog_timeout rose while writes kept arriving at %0t", $time);
            other_err_cnt++;
        end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        logic [31:0] exp_hub [12];                  // round trip data, index = offset
        logic [31:0] wval [3];
        logic [31:0] rd;
        logic        err;
        int          wait_cycles;
        int          seen_before [3];
        int          done_order [$];

        sysclk     = 1'b0;
        rst_n      = 1'b0;
        board_id   = 4'ha;
        wdog_clear = 1'b0;
        wdog_busy  = 1'b0;
        foreach (host_req[h])
            host_req[h] = '0;
        repeat (8) @(posedge sysclk);
        #5;
        rst_n = 1'b1;
        @(negedge sysclk);
        check_true(!(host_rsp[0].pready || host_rsp[1].pready || host_rsp[2].pready),
                   "pready high right after reset");
        check_true(!wdog_timeout, "wdog_timeout high right after reset");

        // hub round trip, each host writes, the next host reads back
        for (int h = 0; h < 3; h++)
            for (int i = 0; i < 4; i++) begin
                next_word(exp_hub[h*4+i]);
                bus_write("hub_round_trip", h, hub_addr(h*4+i), exp_hub[h*4+i]);
            end
        for (int h = 0; h < 3; h++)
            for (int i = 0; i < 4; i++)
                read_check("hub_round_trip", (h + 1) % 3, hub_addr(h*4+i), exp_hub[h*4+i], 1'b0);

        // ------------------------------
        // priority and back-pressure
        // ------------------------------
        for (int h = 0; h < 3; h++) begin
            next_word(wval[h]);
            seen_before[h] = pready_seen[h];
        end
        fork
            begin
                bus_write("priority", 0, hub_addr(20), wval[0]);
                done_order.push_back(0);
            end
            begin
                bus_write("priority", 1, hub_addr(20), wval[1]);
                done_order.push_back(1);
            end
            begin
                bus_write("priority", 2, hub_addr(20), wval[2]);
                done_order.push_back(2);
            end
        join
        for (int h = 0; h < 3; h++) begin
            check_value("priority order", 32'(h), done_order[h]);
            check_value("priority completions", 32'd1, pready_seen[h] - seen_before[h]);
        end
        read_check("priority last writer", 0, hub_addr(20), wval[2], 1'b0);

        // main-space registers
        apb_xfer(1, 1'b0, 16'h0000, 32'd0, rd, err);
        check_value("status board_id", 32'h0000_000a, {28'd0, rd[3:0]});
        @(posedge sysclk);
        #5;
        board_id = 4'h5;
        apb_xfer(2, 1'b0, 16'h0000, 32'd0, rd, err);
        check_value("status board_id", 32'h0000_0005, {28'd0, rd[3:0]});
        read_check("version", 0, 16'h0004, FW_VERSION, 1'b0);
        bus_write("wdog period", 1, 16'h0003, 32'h0000_1234);
        read_check("wdog period", 2, 16'h0003, 32'h0000_1234, 1'b0);
        bus_write("version write", 0, 16'h0004, ~FW_VERSION);
        read_check("version after write", 1, 16'h0004, FW_VERSION, 1'b0);

        // ------------------------------
        // error responses
        // ------------------------------
        read_check("unmapped space", 0, 16'h2000, 32'd0, 1'b1);
        read_check("unmapped space", 1, 16'hf010, 32'd0, 1'b1);
        read_check("undefined main offset", 2, 16'h0001, 32'd0, 1'b1);
        read_check("hub beyond depth", 0, hub_addr(HUB_DEPTH_TB), 32'd0, 1'b1);
        apb_xfer(2, 1'b1, hub_addr(HUB_DEPTH_TB), 32'hdead_beef, rd, err);
        check_value("hub beyond depth write pslverr", 32'd1, {31'd0, err});
        read_check("hub beyond depth write dropped", 1, hub_addr(0), exp_hub[0], 1'b0);

        // watchdog, idle bus after arming
        bus_write("wdog arm", 1, 16'h0003, 32'(WDOG_PERIOD_TB));
        wait_cycles = 0;
        while (!wdog_timeout && wait_cycles < 40) begin
            @(negedge sysclk);
            wait_cycles++;
        end
        check_true(wdog_timeout, "wdog_timeout did not rise on an idle bus");
        check_true(wait_cycles >= WDOG_PERIOD_TB * WDOG_TICK_TB &&
                   wait_cycles <= WDOG_PERIOD_TB * WDOG_TICK_TB + WDOG_TICK_TB,
                   $sformatf("wdog_timeout rose after %0d idle cycles", wait_cycles));
        repeat (8) begin
            @(negedge sysclk);
            check_true(wdog_timeout, "wdog_timeout fell before wdog_clear");
        end
        @(posedge sysclk);
        #5;
        wdog_clear = 1'b1;
        @(posedge sysclk);
        #5;
        wdog_clear = 1'b0;
        repeat (4) begin
            @(negedge sysclk);
            check_true(!wdog_timeout, "wdog_timeout still high after wdog_clear");
        end

        // writes every 6 cycles keep rearming, well inside 3 ticks
        bus_write("wdog rearm", 2, 16'h0003, 32'(WDOG_PERIOD_TB));
        wdog_busy = 1'b1;
        for (int i = 0; i < 16; i++) begin
            next_word(rd);
            bus_write("wdog busy", i % 3, hub_addr(32 + i), rd);
            repeat (2) @(posedge sysclk);
        end
        wdog_busy = 1'b0;

        repeat (2) @(posedge sysclk);
        report_counts();
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge sysclk);
            cycle_cnt++;
        end
        $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        other_err_cnt++;
        report_counts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog/fpga_reg_top.sv
/*
 * Top level of the shared register bus. Three host APB ports go through
 * the priority arbiter onto one bus, which is decoded to the board
 * registers and the hub memory. Parameters are passed to the slaves.
 */

`timescale 1ns/1ps

module fpga_reg_top #(
    parameter int WDOG_TICK = 1000,                 // cycles per watchdog tick
    parameter int HUB_DEPTH = 64                    // hub quadlets
) (
    input  logic              sysclk,
    input  logic              rst_n,
    input  logic [3:0]        board_id,
    input  bus_pkg::apb_req_t rt_req,               // block write engine
    input  bus_pkg::apb_req_t eth_req,              // Ethernet host
    input  bus_pkg::apb_req_t fw_req,               // FireWire host
    output bus_pkg::apb_rsp_t rt_rsp,
    output bus_pkg::apb_rsp_t eth_rsp,
    output bus_pkg::apb_rsp_t fw_rsp,
    input  logic              wdog_clear,
    output logic              wdog_timeout
);

    import bus_pkg::*;

    // ------------------------------
    // internal bus
    // ------------------------------
    apb_req_t bus_req;                              // granted host on the shared bus
    apb_rsp_t bus_rsp;
    apb_req_t main_req;
    apb_rsp_t main_rsp;
    apb_req_t hub_req;
    apb_rsp_t hub_rsp;
    logic     bus_write_done;                       // rearms the watchdog

    host_arbiter arb_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .rt_req(rt_req), .eth_req(eth_req), .fw_req(fw_req),
        .rt_rsp(rt_rsp), .eth_rsp(eth_rsp), .fw_rsp(fw_rsp),
        .bus_req(bus_req), .bus_rsp(bus_rsp),
        .bus_write_done(bus_write_done)
    );

    reg_bus_mux mux_i (
        .bus_req(bus_req), .bus_rsp(bus_rsp),
        .main_req(main_req), .hub_req(hub_req),
        .main_rsp(main_rsp), .hub_rsp(hub_rsp)
    );

    board_regs #(.WDOG_TICK(WDOG_TICK)) chan0_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .main_req(main_req), .main_rsp(main_rsp),
        .board_id(board_id),
        .bus_write_done(bus_write_done),
        .wdog_clear(wdog_clear),
        .wdog_timeout(wdog_timeout)
    );

    hub_mem #(.HUB_DEPTH(HUB_DEPTH)) hub_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .hub_req(hub_req), .hub_rsp(hub_rsp)
    );

endmodule

// File: verilog/hub_mem.sv
/*
 * Hub-space quadlet memory. Indexed by the low paddr bits; offsets at or
 * beyond the depth answer with pslverr and drop writes. Writes land at the
 * end of the access cycle, reads come straight from the array.
 */

`timescale 1ns/1ps

module hub_mem #(
    parameter int HUB_DEPTH = 64                    // quadlets
) (
    input  logic              sysclk,
    input  logic              rst_n,
    input  bus_pkg::apb_req_t hub_req,
    output bus_pkg::apb_rsp_t hub_rsp
);

    import bus_pkg::*;

    localparam int IDX_W = $clog2(HUB_DEPTH);

    logic [DATA_W-1:0] mem [HUB_DEPTH];             // quadlet storage
    logic [11:0]       offset;                      // quadlet offset in the space
    logic [IDX_W-1:0]  idx;
    logic              access;
    logic              in_range;
    logic              mem_we;

    assign offset   = hub_req.paddr[11:0];
    assign idx      = offset[IDX_W-1:0];
    assign access   = hub_req.psel & hub_req.penable;
    assign in_range = (int'(offset) < HUB_DEPTH);

    // ------------------------------
    // write port
    // ------------------------------
    assign mem_we = access & hub_req.pwrite & in_range;  // out-of-range writes dropped

    always_ff @(posedge sysclk) begin
        if (mem_we)
            mem[idx] <= hub_req.pwdata;
    end

    // ------------------------------
    // read port and response
    // ------------------------------
    always_comb begin
        hub_rsp         = '0;
        hub_rsp.pready  = access;                   // zero-wait
        hub_rsp.pslverr = access & ~in_range;
        if (access && in_range && !hub_req.pwrite)
            hub_rsp.prdata = mem[idx];
    end

    // the quadlet that a high offset aliases onto keeps its old value
    a_no_oob_write: assert property (@(posedge sysclk) disable iff (!rst_n)
        (access && hub_req.pwrite && !in_range) |=> (mem[$past(idx)] === $past(mem[idx])));

endmodule

// File: verilog/board_regs.sv
/*
 * Main-space board registers: status (board id, watchdog flag), firmware
 * version and the watchdog period. The watchdog counts ticks of idle bus
 * time and latches a timeout once the count reaches a nonzero period.
 * Any completed write from any host restarts the count.
 */

`timescale 1ns/1ps

module board_regs #(
    parameter int WDOG_TICK = 1000                  // sysclk cycles per watchdog tick
) (
    input  logic              sysclk,
    input  logic              rst_n,
    input  bus_pkg::apb_req_t main_req,
    output bus_pkg::apb_rsp_t main_rsp,
    input  logic [3:0]        board_id,             // rotary switch
    input  logic              bus_write_done,       // write done, any space
    input  logic              wdog_clear,           // external clear, e.g. at power-up
    output logic              wdog_timeout          // sticky timeout flag
);

    import bus_pkg::*;

    localparam int TICK_W = (WDOG_TICK > 1) ? $clog2(WDOG_TICK) : 1;

    reg_offset_e       offset;
    logic              access;                      // access phase, this slave
    logic              bad_off;                     // undefined register
    logic              wdog_wr;                     // period register write
    logic [DATA_W-1:0] rd_val;
    logic [15:0]       wdog_period;                 // 0 -> watchdog off
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic [15:0]       idle_cnt;                    // ticks since last write

    assign offset = reg_offset_e'(main_req.paddr[3:0]);
    assign access = main_req.psel & main_req.penable;

    // ------------------------------
    // register read / write
    // ------------------------------
    always_comb begin
        rd_val  = '0;
        bad_off = 1'b0;
        case (offset)
            REG_STATUS:  rd_val = {27'd0, wdog_timeout, board_id};
            REG_WDOG:    rd_val = {16'd0, wdog_period};
            REG_VERSION: rd_val = FW_VERSION;
            default:     bad_off = 1'b1;
        endcase
        if (main_req.paddr[11:4] != '0)             // channel field must be zero
            bad_off = 1'b1;
    end

    assign main_rsp.pready  = access;
    assign main_rsp.pslverr = access & bad_off;
    assign main_rsp.prdata  = (access && !bad_off) ? rd_val : '0;

    // only the period is writable; status and version ignore writes
    assign wdog_wr = access & main_req.pwrite & ~bad_off & (offset == REG_WDOG);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_period <= '0;
        else if (wdog_wr)
            wdog_period <= main_req.pwdata[15:0];
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    assign tick = (tick_cnt == TICK_W'(WDOG_TICK - 1));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            idle_cnt <= '0;
        end else if (bus_write_done) begin          // rearm, tick phase restarts too
            tick_cnt <= '0;
            idle_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick && idle_cnt != 16'hffff)       // saturate, no second match on wrap
                idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || wdog_wr)
            wdog_timeout <= 1'b0;
        else if (wdog_period != '0 && idle_cnt == wdog_period)
            wdog_timeout <= 1'b1;
    end

    a_wdog_off: assert property (@(posedge sysclk) disable iff (!rst_n)
        (wdog_period == '0) |=> !$rose(wdog_timeout));

endmodule

// File: verilog/reg_bus_mux.sv
/*
 * Address-space decoder on the shared register bus. paddr[15:12] picks the
 * board registers or the hub memory; the selected slave gets psel and
 * returns the response. Unmapped spaces are answered here with an error.
 */

`timescale 1ns/1ps

module reg_bus_mux (
    input  bus_pkg::apb_req_t bus_req,              // from the arbiter
    output bus_pkg::apb_rsp_t bus_rsp,
    output bus_pkg::apb_req_t main_req,             // board registers
    output bus_pkg::apb_req_t hub_req,              // hub memory
    input  bus_pkg::apb_rsp_t main_rsp,
    input  bus_pkg::apb_rsp_t hub_rsp
);

    import bus_pkg::*;

    addr_space_e space;                             // decoded address nibble
    logic        bus_access;                        // access phase on the bus

    assign space      = addr_space_e'(bus_req.paddr[ADDR_W-1:ADDR_W-4]);
    assign bus_access = bus_req.psel & bus_req.penable;

    // ------------------------------
    // slave select and read mux
    // ------------------------------
    always_comb begin
        main_req      = bus_req;                    // shared addr/data/strobes
        main_req.psel = 1'b0;
        hub_req       = bus_req;
        hub_req.psel  = 1'b0;
        bus_rsp       = '0;

        case (space)
            ADDR_MAIN: begin
                main_req.psel = bus_req.psel;
                bus_rsp       = main_rsp;
            end
            ADDR_HUB: begin
                hub_req.psel = bus_req.psel;
                bus_rsp      = hub_rsp;
            end
            default: begin
                // no slave here, complete at once with an error
                bus_rsp.pready  = bus_access;
                bus_rsp.pslverr = bus_access;
                bus_rsp.prdata  = '0;
            end
        endcase
    end

endmodule

// File: verilog/host_arbiter.sv
/*
 * Fixed-priority arbiter for the three host APB ports. One host is granted
 * at a time and its request is replayed onto the shared bus as a setup
 * cycle and an access cycle. Only the granted host sees the response.
 */

`timescale 1ns/1ps

module host_arbiter (
    input  logic              sysclk,
    input  logic              rst_n,
    input  bus_pkg::apb_req_t rt_req,               // highest priority
    input  bus_pkg::apb_req_t eth_req,
    input  bus_pkg::apb_req_t fw_req,               // lowest priority
    output bus_pkg::apb_rsp_t rt_rsp,
    output bus_pkg::apb_rsp_t eth_rsp,
    output bus_pkg::apb_rsp_t fw_rsp,
    output bus_pkg::apb_req_t bus_req,              // to the address decoder
    input  bus_pkg::apb_rsp_t bus_rsp,
    output logic              bus_write_done        // write completes this cycle
);

    import bus_pkg::*;

    arb_state_e state, state_nxt;
    host_e      grant, grant_nxt;                   // owner of the current transfer
    apb_req_t   sel_req;                            // request of the granted host

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb begin
        state_nxt = state;
        grant_nxt = grant;
        case (state)
            ARB_IDLE: begin
                if (rt_req.psel) begin              // priority order rt, eth, fw
                    grant_nxt = HOST_RT;
                    state_nxt = ARB_SETUP;
                end else if (eth_req.psel) begin
                    grant_nxt = HOST_ETH;
                    state_nxt = ARB_SETUP;
                end else if (fw_req.psel) begin
                    grant_nxt = HOST_FW;
                    state_nxt = ARB_SETUP;
                end
            end
            ARB_SETUP:  state_nxt = ARB_ACCESS;
            ARB_ACCESS: begin
                if (bus_rsp.pready) begin           // slaves are zero-wait today
                    state_nxt = ARB_IDLE;
                    grant_nxt = HOST_NONE;
                end
            end
            default: begin
                state_nxt = ARB_IDLE;
                grant_nxt = HOST_NONE;
            end
        endcase
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= HOST_NONE;
        end else begin
            state <= state_nxt;
            grant <= grant_nxt;
        end
    end

    // ------------------------------
    // request forward, response return
    // ------------------------------
    always_comb begin
        case (grant)
            HOST_RT:  sel_req = rt_req;
            HOST_ETH: sel_req = eth_req;
            HOST_FW:  sel_req = fw_req;
            default:  sel_req = '0;
        endcase
        bus_req         = sel_req;
        bus_req.psel    = (state != ARB_IDLE);      // phases come from the FSM, not the host
        bus_req.penable = (state == ARB_ACCESS);
    end

    always_comb begin
        rt_rsp  = '0;                               // non-granted hosts see pready low
        eth_rsp = '0;
        fw_rsp  = '0;
        if (state == ARB_ACCESS) begin
            case (grant)
                HOST_RT:  rt_rsp  = bus_rsp;
                HOST_ETH: eth_rsp = bus_rsp;
                HOST_FW:  fw_rsp  = bus_rsp;
                default:  ;
            endcase
        end
    end

    assign bus_write_done = (state == ARB_ACCESS) & bus_rsp.pready & bus_req.pwrite;

    // ------------------------------
    // checks
    // ------------------------------
    a_penable_psel: assert property (@(posedge sysclk) disable iff (!rst_n)
        bus_req.penable |-> bus_req.psel);
    a_rt_ready:  assert property (@(posedge sysclk) disable iff (!rst_n)
        rt_rsp.pready |-> rt_req.psel);
    a_eth_ready: assert property (@(posedge sysclk) disable iff (!rst_n)
        eth_rsp.pready |-> eth_req.psel);
    a_fw_ready:  assert property (@(posedge sysclk) disable iff (!rst_n)
        fw_rsp.pready |-> fw_req.psel);

endmodule

// File: verilog/bus_pkg.sv
/*
 * Shared definitions for the FPGA register bus: address-space nibbles,
 * main-space register offsets, the APB request/response structs and the
 * arbiter enums. Imported by every RTL module and by the testbench.
 */

package bus_pkg;

    // ------------------------------
    // bus geometry
    // ------------------------------
    localparam int ADDR_W = 16;                     // paddr width
    localparam int DATA_W = 32;                     // quadlet data width

    localparam logic [DATA_W-1:0] FW_VERSION = 32'h0000_0107;  // firmware rev 7

    // paddr[15:12] selects the address space
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0,                           // board registers
        ADDR_HUB  = 4'h1                            // hub quadlet memory
    } addr_space_e;

    // paddr[3:0] inside the main space
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,                         // ro: timeout flag and board id
        REG_WDOG    = 4'd3,                         // rw: watchdog period in ticks
        REG_VERSION = 4'd4                          // ro: firmware version
    } reg_offset_e;

    // ------------------------------
    // APB structs
    // ------------------------------
    typedef struct packed {
        logic              psel;                    // slave select
        logic              penable;                 // access phase
        logic              pwrite;                  // 1 -> write
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;                                    // 51 bits

    typedef struct packed {
        logic              pready;                  // transfer completes this cycle
        logic [DATA_W-1:0] prdata;
        logic              pslverr;                 // error response
    } apb_rsp_t;                                    // 34 bits

    // host ports in priority order, highest first
    typedef enum logic [1:0] {
        HOST_RT,                                    // real-time block write engine
        HOST_ETH,                                   // Ethernet host
        HOST_FW,                                    // FireWire host
        HOST_NONE
    } host_e;

    typedef enum logic [1:0] {
        ARB_IDLE,                                   // sample requests
        ARB_SETUP,                                  // APB setup on the shared bus
        ARB_ACCESS                                  // APB access, pready back to host
    } arb_state_e;

endpackage
